// ==== hdl/cmd_unit_pkg.sv ====
// Sizes are fixed for a 1024-word scratch memory and byte counts are cut to whole 4-byte beats
package cmd_unit_pkg;

    // Stream and memory word
    localparam int data_width     = 32;
    localparam int byte_shift     = 2;
    localparam int addr_width     = 16;

    // Scratch memory where addresses above it wrap
    localparam int ram_depth      = 1024;
    localparam int ram_addr_width = 10;

    // Command word fields
    localparam int opcode_width   = 4;
    localparam int imm_width      = 28;
    localparam int count_width    = imm_width - byte_shift;

    localparam logic [opcode_width-1:0] op_nop    = 4'd0;
    localparam logic [opcode_width-1:0] op_store  = 4'd5;
    localparam logic [opcode_width-1:0] op_load   = 4'd6;
    localparam logic [opcode_width-1:0] op_memset = 4'd7;
    localparam logic [opcode_width-1:0] op_stream = 4'd8;

    // Data source selected in the data path
    localparam int route_width = 3;
    localparam logic [route_width-1:0] route_none  = 3'd0;
    localparam logic [route_width-1:0] route_store = 3'd1;
    localparam logic [route_width-1:0] route_load  = 3'd2;
    localparam logic [route_width-1:0] route_fill  = 3'd3;
    localparam logic [route_width-1:0] route_pass  = 3'd4;

    // Sequencer phases
    localparam int phase_width = 3;
    localparam logic [phase_width-1:0] ph_cmd    = 3'd0;
    localparam logic [phase_width-1:0] ph_addr   = 3'd1;
    localparam logic [phase_width-1:0] ph_value  = 3'd2;
    localparam logic [phase_width-1:0] ph_run    = 3'd3;
    localparam logic [phase_width-1:0] ph_finish = 3'd4;

    // An input word seen as a command or as an address or fill value
    typedef union packed {
        struct packed {
            logic [opcode_width-1:0] opcode;
            logic [imm_width-1:0]    imm;
        } cmd;
        logic [data_width-1:0] raw;
    } cmd_word_u;

endpackage

// ==== hdl/scratch_ram.sv ====
// Contents are not cleared by reset and a read and a write must not share a cycle
`timescale 1ns/1ns

module scratch_ram
    import cmd_unit_pkg::*;
(
    input  logic                      aclk,
    input  logic                      we,
    input  logic                      re,
    input  logic [ram_addr_width-1:0] addr,
    input  logic [data_width-1:0]     wdata,
    output logic [data_width-1:0]     rdata
);

    logic [data_width-1:0] mem [ram_depth];

    // Single port with registered read data
    always_ff @(posedge aclk)
    begin
        if (we)
            mem[addr] <= wdata;
        // Read data holds until the next read
        if (re)
            rdata <= mem[addr];
    end

endmodule

// ==== hdl/beat_counter.sv ====
// Word address wraps at the memory size and byte-address bits above it are ignored
`timescale 1ns/1ns

module beat_counter
    import cmd_unit_pkg::*;
(
    input  logic                      aclk,
    input  logic                      resetn,
    input  logic                      start,
    input  logic [addr_width-1:0]     base_addr,
    input  logic [count_width-1:0]    beat_count,
    input  logic                      step,
    output logic [ram_addr_width-1:0] word_addr,
    output logic                      final_beat,
    output logic                      empty
);

    logic [count_width-1:0] remaining;

    // Beats left in the active operation
    assign empty      = (remaining == '0);
    assign final_beat = (remaining == count_width'(1));

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            remaining <= '0;
            word_addr <= '0;
        end
        else if (start)
        begin
            // Drop the byte offset and the bits above the memory
            word_addr <= base_addr[byte_shift +: ram_addr_width];
            remaining <= beat_count;
        end
        else if (step && !empty)
        begin
            // Natural overflow wraps the word address back to zero
            word_addr <= word_addr + 1'b1;
            remaining <= remaining - 1'b1;
        end
    end

endmodule

// ==== hdl/beat_path.sv ====
// Output queue holds two beats and at most one RAM read is in flight at a time
`timescale 1ns/1ns

module beat_path
    import cmd_unit_pkg::*;
(
    input  logic                   aclk,
    input  logic                   resetn,
    input  logic [route_width-1:0] route,
    input  logic [data_width-1:0]  fill_value,
    input  logic                   s_axis_tvalid,
    input  logic [data_width-1:0]  s_axis_tdata,
    input  logic                   final_beat,
    input  logic                   empty,
    output logic                   take_ok,
    output logic                   step,
    output logic                   drained,
    output logic                   ram_we,
    output logic                   ram_re,
    output logic [data_width-1:0]  ram_wdata,
    input  logic [data_width-1:0]  ram_rdata,
    output logic                   m_axis_tvalid,
    output logic                   m_axis_tlast,
    output logic [data_width-1:0]  m_axis_tdata,
    input  logic                   m_axis_tready
);

    logic [data_width-1:0] q_data [2];
    logic [1:0]            q_last;
    logic [1:0]            q_cnt;
    logic                  wr_ptr;
    logic                  rd_ptr;
    logic                  rd_pend;
    logic                  rd_last;
    logic                  pop;
    logic                  push;
    logic                  push_last;
    logic [data_width-1:0] push_data;
    logic                  take;
    logic                  fill;
    logic                  room;
    logic [2:0]            committed;

    assign pop = m_axis_tvalid && m_axis_tready;

    // Queue slots already promised, counting the read in flight
    assign committed = {1'b0, q_cnt} + {2'b00, rd_pend} - {2'b00, pop};
    assign room      = (committed < 3'd2);

    assign take_ok = !empty && ((route == route_store) || ((route == route_pass) && room));
    assign take    = take_ok && s_axis_tvalid;
    assign fill    = (route == route_fill) && !empty;

    assign ram_re    = (route == route_load) && !empty && room;
    assign ram_we    = ((route == route_store) && take) || fill;
    assign ram_wdata = fill ? fill_value : s_axis_tdata;
    assign step      = take || ram_re || fill;

    // Read data and pass-through beats never arrive together
    assign push      = rd_pend || ((route == route_pass) && take);
    assign push_data = rd_pend ? ram_rdata : s_axis_tdata;
    assign push_last = rd_pend ? rd_last : final_beat;

    assign m_axis_tvalid = (q_cnt != 2'd0);
    assign m_axis_tdata  = q_data[rd_ptr];
    assign m_axis_tlast  = m_axis_tvalid && q_last[rd_ptr];
    assign drained       = (q_cnt == 2'd0) && !rd_pend;

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            q_cnt   <= 2'd0;
            wr_ptr  <= 1'b0;
            rd_ptr  <= 1'b0;
            rd_pend <= 1'b0;
        end
        else
        begin
            rd_pend <= ram_re;
            if (push)
                wr_ptr <= !wr_ptr;
            if (pop)
                rd_ptr <= !rd_ptr;
            q_cnt <= q_cnt + {1'b0, push} - {1'b0, pop};
        end
    end

    always_ff @(posedge aclk)
    begin
        // Tag the read so tlast follows the final beat through the RAM
        if (ram_re)
            rd_last <= final_beat;
        if (push)
        begin
            q_data[wr_ptr] <= push_data;
            q_last[wr_ptr] <= push_last;
        end
    end

endmodule

// ==== hdl/cmd_ctrl.sv ====
// Unknown opcodes and zero-beat counts are dropped silently and the next command waits for drain
`timescale 1ns/1ns

module cmd_ctrl
    import cmd_unit_pkg::*;
(
    input  logic                   aclk,
    input  logic                   resetn,
    input  logic                   s_axis_tvalid,
    input  logic [data_width-1:0]  s_axis_tdata,
    output logic                   s_axis_tready,
    input  logic                   take_ok,
    input  logic                   empty,
    input  logic                   drained,
    output logic                   start,
    output logic [addr_width-1:0]  base_addr,
    output logic [count_width-1:0] beat_count,
    output logic [route_width-1:0] route,
    output logic [data_width-1:0]  fill_value
);

    cmd_word_u               in_word;
    logic [phase_width-1:0]  phase;
    logic [opcode_width-1:0] opcode_q;
    logic [count_width-1:0]  count_q;
    logic [addr_width-1:0]   addr_q;
    logic [count_width-1:0]  cmd_count;
    logic                    known_op;
    logic                    accept;

    assign in_word   = s_axis_tdata;
    assign cmd_count = in_word.cmd.imm[imm_width-1:byte_shift];
    assign accept    = s_axis_tvalid && s_axis_tready;

    always_comb
    begin
        case (in_word.cmd.opcode)
            op_store, op_load, op_memset, op_stream: known_op = 1'b1;
            op_nop:  known_op = 1'b0;
            default: known_op = 1'b0;
        endcase
    end

    // Route is only active while beats are being issued
    always_comb
    begin
        route = route_none;
        if (phase == ph_run)
        begin
            case (opcode_q)
                op_store:  route = route_store;
                op_load:   route = route_load;
                op_memset: route = route_fill;
                op_stream: route = route_pass;
                default:   route = route_none;
            endcase
        end
    end

    always_comb
    begin
        case (phase)
            ph_cmd, ph_addr, ph_value: s_axis_tready = 1'b1;
            ph_run: s_axis_tready = ((route == route_store) || (route == route_pass)) && take_ok;
            default: s_axis_tready = 1'b0;
        endcase
    end

    // Start fires on the handshake of the last operand
    always_comb
    begin
        start = 1'b0;
        if (accept)
        begin
            case (phase)
                ph_cmd:
                    start = known_op && (cmd_count != '0) && (in_word.cmd.opcode == op_stream);
                ph_addr:  start = (opcode_q != op_memset);
                ph_value: start = 1'b1;
                default:  start = 1'b0;
            endcase
        end
    end

    assign base_addr  = (phase == ph_value) ? addr_q : in_word.raw[addr_width-1:0];
    assign beat_count = (phase == ph_cmd) ? cmd_count : count_q;

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            // Finish phase holds ready low for one cycle after reset
            phase    <= ph_finish;
            opcode_q <= op_nop;
        end
        else
        begin
            case (phase)
                ph_cmd:
                begin
                    if (accept && known_op && (cmd_count != '0))
                    begin
                        opcode_q <= in_word.cmd.opcode;
                        phase    <= (in_word.cmd.opcode == op_stream) ? ph_run : ph_addr;
                    end
                end
                ph_addr:
                begin
                    if (accept)
                        phase <= (opcode_q == op_memset) ? ph_value : ph_run;
                end
                ph_value:
                begin
                    if (accept)
                        phase <= ph_run;
                end
                ph_run:
                begin
                    if (empty)
                        phase <= ph_finish;
                end
                ph_finish:
                begin
                    if (empty && drained)
                        phase <= ph_cmd;
                end
                default: phase <= ph_finish;
            endcase
        end
    end

    // Operand registers
    always_ff @(posedge aclk)
    begin
        if (accept && (phase == ph_cmd))
            count_q <= cmd_count;
        if (accept && (phase == ph_addr))
            addr_q <= in_word.raw[addr_width-1:0];
        if (accept && (phase == ph_value))
            fill_value <= in_word.raw;
    end

endmodule

// ==== hdl/cmd_unit_top.sv ====
// Input stream has no tlast and the scratch memory is internal with no external bus
`timescale 1ns/1ns

module cmd_unit_top
    import cmd_unit_pkg::*;
(
    input  logic                  aclk,
    input  logic                  resetn,

    // Command and data input
    input  logic                  s_axis_tvalid,
    output logic                  s_axis_tready,
    input  logic [data_width-1:0] s_axis_tdata,

    // Load and pass output
    output logic                  m_axis_tvalid,
    input  logic                  m_axis_tready,
    output logic                  m_axis_tlast,
    output logic [data_width-1:0] m_axis_tdata
);

    // Sequencer to counter
    logic                      start;
    logic [addr_width-1:0]     base_addr;
    logic [count_width-1:0]    beat_count;

    // Sequencer to data path
    logic [route_width-1:0]    route;
    logic [data_width-1:0]     fill_value;
    logic                      take_ok;
    logic                      drained;

    // Counter status and advance
    logic                      step;
    logic [ram_addr_width-1:0] word_addr;
    logic                      final_beat;
    logic                      empty;

    // Memory port
    logic                      ram_we;
    logic                      ram_re;
    logic [data_width-1:0]     ram_wdata;
    logic [data_width-1:0]     ram_rdata;

    cmd_ctrl ctrl_i (
        .aclk          (aclk),
        .resetn        (resetn),
        .s_axis_tvalid (s_axis_tvalid),
        .s_axis_tdata  (s_axis_tdata),
        .s_axis_tready (s_axis_tready),
        .take_ok       (take_ok),
        .empty         (empty),
        .drained       (drained),
        .start         (start),
        .base_addr     (base_addr),
        .beat_count    (beat_count),
        .route         (route),
        .fill_value    (fill_value)
    );

    beat_counter counter_i (
        .aclk       (aclk),
        .resetn     (resetn),
        .start      (start),
        .base_addr  (base_addr),
        .beat_count (beat_count),
        .step       (step),
        .word_addr  (word_addr),
        .final_beat (final_beat),
        .empty      (empty)
    );

    beat_path path_i (
        .aclk          (aclk),
        .resetn        (resetn),
        .route         (route),
        .fill_value    (fill_value),
        .s_axis_tvalid (s_axis_tvalid),
        .s_axis_tdata  (s_axis_tdata),
        .final_beat    (final_beat),
        .empty         (empty),
        .take_ok       (take_ok),
        .step          (step),
        .drained       (drained),
        .ram_we        (ram_we),
        .ram_re        (ram_re),
        .ram_wdata     (ram_wdata),
        .ram_rdata     (ram_rdata),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tlast  (m_axis_tlast),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tready (m_axis_tready)
    );

    // Address comes straight from the counter
    scratch_ram ram_i (
        .aclk  (aclk),
        .we    (ram_we),
        .re    (ram_re),
        .addr  (word_addr),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

endmodule

// ==== verif/clk_gen.sv ====
// Free-running 100 ns clock and a reset that is released 10 ns after the third rising edge
`timescale 1ns/1ns

module clk_gen
(
    output logic aclk,
    output logic resetn
);

    initial
    begin
        aclk = 1'b0;
        forever
            #50 aclk = !aclk;
    end

    // Reset held low over three rising edges
    initial
    begin
        resetn = 1'b0;
        repeat (3) @(posedge aclk);
        #10;
        resetn = 1'b1;
    end

endmodule

// ==== verif/cmd_unit_asserts.sv ====
// Output-stream protocol checks that assume the testbench holds its own drives low in reset
`timescale 1ns/1ns

module cmd_unit_asserts
    import cmd_unit_pkg::*;
(
    input logic                  aclk,
    input logic                  resetn,
    input logic                  s_axis_tvalid,
    input logic                  s_axis_tready,
    input logic                  m_axis_tvalid,
    input logic                  m_axis_tready,
    input logic                  m_axis_tlast,
    input logic [data_width-1:0] m_axis_tdata
);

    int   violations = 0;
    logic reset_held;

    // High from the second cycle of reset, once the DUT registers are defined
    always_ff @(posedge aclk)
        reset_held <= !resetn;

    // A stalled beat keeps its data and tlast until taken
    stall_stable: assert property (@(posedge aclk) disable iff (!resetn)
        (m_axis_tvalid && !m_axis_tready) |=>
        (m_axis_tvalid && $stable(m_axis_tdata) && $stable(m_axis_tlast)))
    else
    begin
        violations++;
        $error("m_axis beat changed while stalled");
    end

    last_with_valid: assert property (@(posedge aclk) disable iff (!resetn)
        m_axis_tlast |-> m_axis_tvalid)
    else
    begin
        violations++;
        $error("m_axis_tlast high without m_axis_tvalid");
    end

    reset_quiet: assert property (@(posedge aclk)
        (reset_held && !resetn) |->
        (!s_axis_tvalid && !s_axis_tready && !m_axis_tvalid && !m_axis_tready))
    else
    begin
        violations++;
        $error("stream valid or ready high during reset");
    end

endmodule

bind cmd_unit_top cmd_unit_asserts asserts_i (
    .aclk          (aclk),
    .resetn        (resetn),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tready (s_axis_tready),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready),
    .m_axis_tlast  (m_axis_tlast),
    .m_axis_tdata  (m_axis_tdata)
);

// ==== verif/cmd_unit_tb.sv ====
// Loads only read words written earlier in the run because the scratch memory starts undefined
`timescale 1ns/1ns

module cmd_unit_tb
    import cmd_unit_pkg::*;
();

    logic                  aclk;
    logic                  resetn;
    logic                  s_axis_tvalid;
    logic                  s_axis_tready;
    logic [data_width-1:0] s_axis_tdata;
    logic                  m_axis_tvalid;
    logic                  m_axis_tready;
    logic                  m_axis_tlast;
    logic [data_width-1:0] m_axis_tdata;

    // Memory model, words of the current pass and the beats still to come out
    logic [data_width-1:0] model_mem [ram_depth];
    logic [data_width-1:0] stream_in [$];
    logic [data_width-1:0] exp_data_q [$];
    logic                  exp_last_q [$];

    int errors          = 0;
    int beats_checked   = 0;
    int errors_at_start = 0;
    int beats_at_start  = 0;
    int cycles          = 0;
    int cycle_limit;
    bit bp_on;

    // Beat counts of the tests
    int pass_n      = 8;
    int store_n     = 10;
    int near_n      = 12;
    int fill_n      = 4;
    int bp_n        = 24;
    int bp_pass_n   = 20;
    int skip_pass_n = 5;
    int wrap_n      = 6;

    clk_gen clk_gen_i (
        .aclk   (aclk),
        .resetn (resetn)
    );

    cmd_unit_top dut_i (
        .aclk          (aclk),
        .resetn        (resetn),
        .s_axis_tvalid (s_axis_tvalid),
        .s_axis_tready (s_axis_tready),
        .s_axis_tdata  (s_axis_tdata),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tready (m_axis_tready),
        .m_axis_tlast  (m_axis_tlast),
        .m_axis_tdata  (m_axis_tdata)
    );

    // Input words plus output or fill beats over all tests
    function automatic int planned_beats();
        return (1 + 2 * pass_n) + 2 * (2 + store_n)
             + 2 * (2 + near_n) + (3 + fill_n)
             + 2 * (2 + bp_n) + (1 + 2 * bp_pass_n)
             + 4 + (1 + 2 * skip_pass_n) + 2 * (2 + wrap_n);
    endfunction

    // Byte address to word index with the offset and the bits above the memory dropped
    function automatic int word_index(input logic [addr_width-1:0] addr);
        return (int'(addr) >> byte_shift) % ram_depth;
    endfunction

    function automatic logic [data_width-1:0] command(input logic [opcode_width-1:0] op,
                                                      input int bytes);
        cmd_word_u word;
        word.cmd.opcode = op;
        word.cmd.imm    = imm_width'(bytes);
        return word.raw;
    endfunction

    // Beat k of an n-beat load from base_word, or of the current pass
    function automatic void expected_beat(input bit from_ram, input int base_word, input int k,
                                          input int n, output logic [data_width-1:0] word,
                                          output logic last);
        if (from_ram)
            word = model_mem[(base_word + k) % ram_depth];
        else
            word = stream_in[k];
        last = (k == n - 1);
    endfunction

    task automatic check_data(input logic [data_width-1:0] got, input logic [data_width-1:0] exp);
        beats_checked++;
        if (got !== exp)
        begin
            errors++;
            $display("FAIL m_axis_tdata got %h expected %h", got, exp);
        end
    endtask

    task automatic check_last(input logic got, input logic exp);
        if (got !== exp)
        begin
            errors++;
            $display("FAIL m_axis_tlast got %h expected %h", got, exp);
        end
    endtask

    // Holds the word until the handshake, returns at the next drive point
    task automatic send_word(input logic [data_width-1:0] word);
        s_axis_tvalid = 1'b1;
        s_axis_tdata  = word;
        do
            @(negedge aclk);
        while (s_axis_tready !== 1'b1);
        @(posedge aclk);
        #10;
        s_axis_tvalid = 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge aclk);
        #10;
    endtask

    task automatic store_burst(input logic [addr_width-1:0] addr, input int n, input int extra);
        int                    base;
        int                    k;
        logic [data_width-1:0] word;
        base = word_index(addr);
        send_word(command(op_store, (n << byte_shift) + extra));
        send_word(data_width'(addr));
        for (k = 0; k < n; k++)
        begin
            word = $urandom;
            model_mem[(base + k) % ram_depth] = word;
            send_word(word);
        end
    endtask

    task automatic fill_range(input logic [addr_width-1:0] addr, input int n,
                              input logic [data_width-1:0] value);
        int base;
        int k;
        base = word_index(addr);
        for (k = 0; k < n; k++)
            model_mem[(base + k) % ram_depth] = value;
        send_word(command(op_memset, n << byte_shift));
        send_word(data_width'(addr));
        send_word(value);
    endtask

    task automatic load_burst(input logic [addr_width-1:0] addr, input int n);
        int                    k;
        logic [data_width-1:0] word;
        logic                  last;
        for (k = 0; k < n; k++)
        begin
            expected_beat(1'b1, word_index(addr), k, n, word, last);
            exp_data_q.push_back(word);
            exp_last_q.push_back(last);
        end
        send_word(command(op_load, n << byte_shift));
        send_word(data_width'(addr));
    endtask

    task automatic stream_burst(input int n);
        int                    k;
        logic [data_width-1:0] word;
        logic                  last;
        stream_in.delete();
        for (k = 0; k < n; k++)
            stream_in.push_back($urandom);
        for (k = 0; k < n; k++)
        begin
            expected_beat(1'b0, 0, k, n, word, last);
            exp_data_q.push_back(word);
            exp_last_q.push_back(last);
        end
        send_word(command(op_stream, n << byte_shift));
        for (k = 0; k < n; k++)
            send_word(stream_in[k]);
    endtask

    task automatic end_test(input string name);
        while (exp_data_q.size() != 0)
            @(negedge aclk);
        $display("%-12s %0d beats checked, %0d mismatches", name,
                 beats_checked - beats_at_start, errors - errors_at_start);
        beats_at_start  = beats_checked;
        errors_at_start = errors;
        @(posedge aclk);
        #10;
    endtask

    // Compare every output handshake with the next expected beat
    always @(negedge aclk)
    begin
        if ((resetn === 1'b1) && (m_axis_tvalid === 1'b1) && (m_axis_tready === 1'b1))
        begin
            if (exp_data_q.size() == 0)
            begin
                errors++;
                $display("Unexpected output beat %h while no beat was due", m_axis_tdata);
            end
            else
            begin
                check_data(m_axis_tdata, exp_data_q.pop_front());
                check_last(m_axis_tlast, exp_last_q.pop_front());
            end
        end
    end

    // Output ready goes random while back-pressure is on
    initial
    begin
        m_axis_tready = 1'b0;
        wait (resetn === 1'b1);
        forever
        begin
            @(posedge aclk);
            #10;
            m_axis_tready = bp_on ? ($urandom % 4 != 0) : 1'b1;
        end
    end

    initial
    begin
        do
        begin
            @(posedge aclk);
            cycles++;
        end
        while (cycles <= cycle_limit);
        $display("Timeout after %0d cycles with %0d beats still due", cycles, exp_data_q.size());
        $display("Errors found");
        $finish;
    end

    initial
    begin
        void'($urandom(32'h2f80));
        s_axis_tvalid = 1'b0;
        s_axis_tdata  = '0;
        bp_on         = 1'b0;
        cycle_limit   = 8 * planned_beats() + 200;
        wait (resetn === 1'b1);
        @(posedge aclk);
        #10;

        stream_burst(pass_n);
        end_test("pass");

        // Ragged byte count is cut to whole beats
        store_burst(16'h0040, store_n, 3);
        load_burst(16'h0040, store_n);
        end_test("store_load");

        store_burst(16'h0190, near_n, 0);
        fill_range(16'h01a0, fill_n, 32'ha5a5_5a5a);
        load_burst(16'h0190, near_n);
        end_test("fill");

        bp_on = 1'b1;
        store_burst(16'h0800, bp_n, 0);
        load_burst(16'h0800, bp_n);
        stream_burst(bp_pass_n);
        end_test("backpressure");
        bp_on = 1'b0;

        // NOP, unknown opcode and two zero-beat commands
        send_word(command(op_nop, 64));
        send_word(command(4'hb, 32));
        send_word(command(op_load, 3));
        send_word(command(op_memset, 0));
        idle_cycles(10);
        stream_burst(skip_pass_n);
        end_test("ignored");

        // Starts at word 1021 with high address bits set
        store_burst(16'hfff4, wrap_n, 0);
        load_burst(16'h0ff4, wrap_n);
        end_test("wrap");

        // A repeated final beat would still show up here
        idle_cycles(10);

        $display("Summary %0d beats checked, %0d mismatches, %0d assertion failures",
                 beats_checked, errors, dut_i.asserts_i.violations);
        if ((errors == 0) && (dut_i.asserts_i.violations == 0))
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

// ==== cmd_unit.f ====
hdl/cmd_unit_pkg.sv
hdl/scratch_ram.sv
hdl/beat_counter.sv
hdl/beat_path.sv
hdl/cmd_ctrl.sv
hdl/cmd_unit_top.sv
verif/clk_gen.sv
verif/cmd_unit_asserts.sv
verif/cmd_unit_tb.sv

// ==== Makefile ====
# Verilator lint, simulation and clean for the command-stream unit
# Override any variable on the command line, for example make sim OBJ_DIR=build

VERILATOR  ?= verilator
TOP        ?= cmd_unit_tb
FILELIST   ?= cmd_unit.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --timing --assert -Wno-fatal
LINT_FLAGS ?= -Wall
SIM_ARGS   ?= +verilator+error+limit+1000
PASS_TEXT  ?= No errors

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# The run passes only if the pass line appears in the output
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
